/* Bender.yml */
package:
  name: control_unit

sources:
  - files:
      - hw/control_pkg.sv
      - hw/instr_decoder.sv
      - hw/step_sequencer.sv
      - hw/control_word_gen.sv
      - hw/control_unit.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/control_unit_tb.sv

/* bench/clock_gen.sv */
module clock_gen (
    input  logic restart,                           // Pulse asks for another reset
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;                     // Period 40
        end
    end

    // Reset held for 5 rising edges, released just after the last one
    initial begin
        reset = 1'b1;
        forever begin
            repeat (5) @(posedge clock);
            #1 reset = 1'b0;
            @(posedge restart);
            reset = 1'b1;                           // Asynchronous, no edge needed
        end
    end

endmodule

/* bench/control_unit_tb.sv */
module control_unit_tb import control_pkg::*; ();

    typedef enum int {
        k_add, k_sub, k_and, k_slt, k_addi, k_slti, k_slli, k_srli, k_srai, k_nop,
        k_ld, k_lb, k_lh, k_lw, k_lbu, k_lhu, k_lwu, k_sd, k_sw, k_sh, k_sb,
        k_beq, k_bne, k_bge, k_blt, k_lui, k_jal, k_jalr, k_illegal, k_break
    } kind_e;

    logic                   clock;
    logic                   reset;
    logic                   restart;
    logic [instr_width-1:0] instruction;
    alu_flags_t             flags;
    ctrl_word_t             ctrl;
    step_e                  step;

    kind_e       kinds[$];                          // Instruction list
    logic [31:0] words[$];
    step_e       path[0:4];                         // Expected steps after fetch
    int          path_len;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 1000;

    clock_gen u_clock_gen (
        .restart (restart),
        .clock   (clock),
        .reset   (reset)
    );

    control_unit uut (
        .clock       (clock),
        .reset       (reset),
        .instruction (instruction),
        .flags       (flags),
        .ctrl        (ctrl),
        .step        (step)
    );

    // Encoding with random registers and immediates
    function automatic logic [31:0] encode(input kind_e kind, input logic [31:0] r);
        logic [31:0] w;
        case (kind)
            k_add:  w = {7'b000_0000, r[24:15], 3'd0, r[11:7], op_reg};
            k_sub:  w = {7'b010_0000, r[24:15], 3'd0, r[11:7], op_reg};
            k_and:  w = {7'b000_0000, r[24:15], 3'd7, r[11:7], op_reg};
            k_slt:  w = {7'b000_0000, r[24:15], 3'd2, r[11:7], op_reg};
            k_addi: w = {r[31:15], 3'd0, r[11:8], 1'b1, op_imm};   // Odd rd keeps it off nop
            k_slti: w = {r[31:15], 3'd2, r[11:7], op_imm};
            k_slli: w = {6'b00_0000, r[25:15], 3'd1, r[11:7], op_imm};
            k_srli: w = {6'b00_0000, r[25:15], 3'd5, r[11:7], op_imm};
            k_srai: w = {6'b01_0000, r[25:15], 3'd5, r[11:7], op_imm};
            k_nop:  w = 32'h0000_0013;              // addi x0, x0, 0
            k_lb:   w = {r[31:15], 3'd0, r[11:7], op_load};
            k_lh:   w = {r[31:15], 3'd1, r[11:7], op_load};
            k_lw:   w = {r[31:15], 3'd2, r[11:7], op_load};
            k_ld:   w = {r[31:15], 3'd3, r[11:7], op_load};
            k_lbu:  w = {r[31:15], 3'd4, r[11:7], op_load};
            k_lhu:  w = {r[31:15], 3'd5, r[11:7], op_load};
            k_lwu:  w = {r[31:15], 3'd6, r[11:7], op_load};
            k_sb:   w = {r[31:15], 3'd0, r[11:7], op_store};
            k_sh:   w = {r[31:15], 3'd1, r[11:7], op_store};
            k_sw:   w = {r[31:15], 3'd2, r[11:7], op_store};
            k_sd:   w = {r[31:15], 3'd7, r[11:7], op_store};
            k_beq:  w = {r[31:15], 3'd0, r[11:7], op_branch};
            k_bne:  w = {r[31:15], 3'd1, r[11:7], op_branch_jalr};
            k_blt:  w = {r[31:15], 3'd4, r[11:7], op_branch_jalr};
            k_bge:  w = {r[31:15], 3'd5, r[11:7], op_branch_jalr};
            k_jalr: w = {r[31:15], 3'd0, r[11:7], op_branch_jalr};
            k_lui:  w = {r[31:7], op_lui};
            k_jal:  w = {r[31:7], op_jal};
            k_illegal: w = {7'b000_0000, r[24:15], 3'd6, r[11:7], op_reg};  // or is not kept
            default: w = 32'h0010_0073;             // ebreak
        endcase
        return w;
    endfunction

    // Class and execute settings from the decode table
    function automatic decoded_t table_row(input kind_e kind);
        decoded_t d;
        d.cls = cls_nop;
        d.branch_kind = br_eq;
        d.alu_op = alu_pass_a;
        d.src_b = src_b_reg;
        d.shift = sh_none;
        case (kind)
            k_add, k_sub, k_and: d.cls = cls_alu_reg;
            k_slt, k_slti: d.cls = cls_set_less;
            k_addi: d.cls = cls_alu_imm;
            k_slli, k_srli, k_srai: d.cls = cls_shift;
            k_ld, k_lb, k_lh, k_lw, k_lbu, k_lhu, k_lwu: d.cls = cls_load;
            k_sd, k_sw, k_sh, k_sb: d.cls = cls_store;
            k_beq, k_bne, k_bge, k_blt: d.cls = cls_branch;
            k_lui: d.cls = cls_lui;
            k_jal: d.cls = cls_jal;
            k_jalr: d.cls = cls_jalr;
            k_break: d.cls = cls_break;
            default: ;                              // nop and illegal
        endcase
        if (kind inside {k_add, k_addi, k_lui} || d.cls inside {cls_load, cls_store}) begin
            d.alu_op = alu_add;
        end
        if (kind == k_sub) d.alu_op = alu_sub;
        if (kind == k_and) d.alu_op = alu_and;
        if (d.cls inside {cls_set_less, cls_branch}) d.alu_op = alu_compare;
        if (kind inside {k_addi, k_slti, k_lui} || d.cls inside {cls_load, cls_store}) begin
            d.src_b = src_b_imm;
        end
        if (kind == k_slli) d.shift = sh_left;
        if (kind == k_srli) d.shift = sh_right_logic;
        if (kind == k_srai) d.shift = sh_right_arith;
        if (kind == k_bne) d.branch_kind = br_ne;
        if (kind == k_bge) d.branch_kind = br_ge;
        if (kind == k_blt) d.branch_kind = br_lt;
        return d;
    endfunction

    // Step sequence after fetch, per class
    task automatic load_path(input instr_class_e cls);
        path_len = 2;
        path[0] = st_decode;
        path[1] = st_write_alu;
        case (cls)
            cls_set_less: begin
                path[1] = st_set_flag;
                path[2] = st_write_alu;
                path_len = 3;
            end
            cls_load: begin
                path[1] = st_mem_read;
                path[2] = st_write_mem;
                path_len = 3;
            end
            cls_store: path[1] = st_mem_write;
            cls_branch: path[1] = st_jump;
            cls_jal, cls_jalr: begin
                path[2] = st_jump;
                path_len = 3;
            end
            cls_nop: path_len = 1;
            cls_break: begin
                path = '{st_decode, st_decode, st_decode, st_decode, st_decode};  // Parked
                path_len = 5;
            end
            default: ;                              // alu_reg, alu_imm, shift, lui
        endcase
    endtask

    function automatic logic branch_taken(input branch_kind_e kind, input alu_flags_t f);
        if (kind == br_eq) return f.equal;
        if (kind == br_ne) return !f.equal;
        if (kind == br_ge) return !f.less;
        return f.less;
    endfunction

    // Reference control word from the per-step rules
    function automatic ctrl_word_t expected_word(
        input step_e s, input decoded_t row, input alu_flags_t f
    );
        ctrl_word_t w;
        logic link;
        link = (row.cls == cls_jal) || (row.cls == cls_jalr);
        w = '{pc_write: 1'b0, alu_op: alu_pass_a, src_a: src_a_pc, src_b: src_b_reg,
              shift: sh_none, reg_a_write: 1'b0, reg_b_write: 1'b0, clear_a: 1'b0,
              data_mem_write: 1'b0, mem_data_write: 1'b0, reg_file_write: 1'b0,
              wb_sel: wb_alu};
        if (s == st_idle) w.clear_a = 1'b1;
        if (s == st_fetch) begin
            w.pc_write = 1'b1;
            w.alu_op = alu_add;
            w.src_b = src_b_four;
            w.wb_sel = wb_memory;
        end
        if (s == st_decode) begin
            w.reg_a_write = 1'b1;
            w.reg_b_write = 1'b1;
            w.alu_op = row.alu_op;
            w.src_b = row.src_b;
            w.shift = row.shift;
            w.src_a = link ? src_a_pc : src_a_reg;
            w.clear_a = (row.cls == cls_lui);
        end
        if (s == st_set_flag) begin
            w.clear_a = 1'b1;
            w.src_a = src_a_reg;
            w.alu_op = f.less ? alu_inc_a : alu_pass_a;
        end
        if (s == st_write_alu) w.reg_file_write = 1'b1;     // Link case keeps pass_a and pc
        if (s == st_write_mem) begin
            w.reg_file_write = 1'b1;
            w.wb_sel = wb_memory;
        end
        if (s == st_mem_read) w.mem_data_write = 1'b1;
        if (s == st_mem_write) w.data_mem_write = 1'b1;
        if (s == st_jump) begin
            if (link || (row.cls == cls_branch && branch_taken(row.branch_kind, f))) begin
                w.pc_write = 1'b1;
                w.alu_op = alu_add;
                w.src_a = (row.cls == cls_jalr) ? src_a_reg : src_a_pc;
                w.src_b = (row.cls == cls_jalr) ? src_b_imm : src_b_branch_imm;
            end
        end
        return w;
    endfunction

    task automatic report_value(
        input string name, input logic [31:0] expected, input logic [31:0] actual
    );
        errors++;
        $display("error %s: expected %0h actual %0h", name, expected, actual);
    endtask

    task automatic report_plain(input string text);
        errors++;
        $display("%s", text);
    endtask

    task automatic randomize_flags();
        logic [31:0] r;
        r = $urandom;
        flags.equal = r[0];
        flags.less  = r[1];
    endtask

    // Samples at the falling edge away from input changes
    task automatic check_cycle(input string name, input step_e exp_step, input decoded_t row);
        ctrl_word_t exp_ctrl;
        @(negedge clock);
        exp_ctrl = expected_word(exp_step, row, flags);
        checks++;
        assert (step === exp_step)
        else report_value({name, " step"}, 32'(exp_step), 32'(step));
        assert (ctrl === exp_ctrl)
        else report_value({name, " ctrl"}, 32'(exp_ctrl), 32'(ctrl));
    endtask

    // Idle while reset is high and for the cycle after release
    task automatic run_reset_phase(input string name);
        decoded_t row;
        row = table_row(k_nop);
        while (reset) begin
            check_cycle(name, st_idle, row);
            @(posedge clock);
            #2 randomize_flags();
        end
        check_cycle(name, st_idle, row);
        @(posedge clock);
        #2 randomize_flags();
    endtask

    always @(negedge clock) begin
        if (cycles > 0) begin                       // From the first rising edge on
            if (reset) begin
                assert (step === st_idle && ctrl.clear_a === 1'b1)
                else report_plain("step left idle or clear_a dropped while reset was high");
            end
            assert (step <= st_mem_write)
            else report_plain("step register holds an unused encoding");
        end
    end

    // Watchdog
    always @(posedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("run stopped at cycle limit %0d before the list finished", cycle_limit);
            $display("checks %0d errors %0d", checks, errors + 1);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        decoded_t    row;
        void'($urandom(32'h2d97_8f0b));
        instruction = '0;
        flags       = '0;
        restart     = 1'b0;
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k <= int'(k_illegal); k++) begin
                r = $urandom;
                kinds.push_back(kind_e'(k));
                words.push_back(encode(kind_e'(k), r));
            end
        end
        repeat (4) begin
            kinds.push_back(k_break);
            words.push_back(encode(k_break, 32'd0));
        end
        cycle_limit = kinds.size() * 4 + 20 * 5 + 50;   // 4 resets plus power on
        #2;
        run_reset_phase("power on reset");
        for (int i = 0; i < kinds.size(); i++) begin
            row = table_row(kinds[i]);
            load_path(row.cls);
            instruction = words[i];                 // Loaded during fetch
            randomize_flags();
            check_cycle(kinds[i].name(), st_fetch, row);
            for (int s = 0; s < path_len; s++) begin
                @(posedge clock);
                #2 randomize_flags();
                check_cycle(kinds[i].name(), path[s], row);
            end
            @(posedge clock);
            #2 randomize_flags();
            if (row.cls == cls_break) begin
                restart = 1'b1;
                wait (reset);
                restart = 1'b0;
                run_reset_phase("reset after break");
            end
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* build.f */
hw/control_pkg.sv
hw/instr_decoder.sv
hw/step_sequencer.sv
hw/control_word_gen.sv
hw/control_unit.sv
bench/clock_gen.sv
bench/control_unit_tb.sv

/* hw/control_pkg.sv */
package control_pkg;

    localparam int instr_width = 32;                // Instruction register width

    localparam logic [6:0] funct7_base = 7'b000_0000;   // add, and, slt
    localparam logic [6:0] funct7_alt  = 7'b010_0000;   // sub
    localparam logic [5:0] funct6_logic = 6'b00_0000;   // slli, srli
    localparam logic [5:0] funct6_arith = 6'b01_0000;   // srai

    // Major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_load        = 7'd3,                      // ld, lb, lh, lw, lbu, lhu, lwu
        op_imm         = 7'd19,                     // addi, slti, shifts, nop
        op_store       = 7'd35,                     // sd, sw, sh, sb
        op_reg         = 7'd51,                     // add, sub, and, slt
        op_lui         = 7'd55,                     // Upper immediate
        op_branch      = 7'd99,                     // beq
        op_branch_jalr = 7'd103,                    // bne, bge, blt and jalr share it
        op_jal         = 7'd111,                    // Jump and link
        op_system      = 7'd115                     // break
    } opcode_e;

    // Decoded instruction class, picks the step sequence
    typedef enum logic [3:0] {
        cls_alu_reg,                                // Register to register ALU op
        cls_alu_imm,                                // addi
        cls_shift,                                  // slli, srli, srai
        cls_set_less,                               // slt, slti
        cls_load,
        cls_store,
        cls_branch,                                 // Conditional branches
        cls_lui,
        cls_jal,
        cls_jalr,
        cls_nop,                                    // Also every unknown encoding
        cls_break                                   // Parks the unit
    } instr_class_e;

    typedef enum logic [1:0] {
        br_eq,
        br_ne,
        br_ge,
        br_lt
    } branch_kind_e;

    // Control steps, encoding kept from the original sequencer
    typedef enum logic [3:0] {
        st_idle      = 4'd0,                        // Held in reset
        st_fetch     = 4'd1,                        // PC + 4, instruction register loads
        st_decode    = 4'd2,                        // Operand registers load
        st_jump      = 4'd3,                        // PC update for branch and jumps
        st_write_alu = 4'd4,                        // ALU result to rd
        st_write_mem = 4'd5,                        // Memory data register to rd
        st_set_flag  = 4'd6,                        // slt result from less flag
        st_mem_read  = 4'd7,                        // Load data into memory data register
        st_mem_write = 4'd8                         // Store to data memory
    } step_e;

    typedef enum logic [2:0] {
        alu_pass_a  = 3'd0,                         // Result is A
        alu_add     = 3'd1,
        alu_sub     = 3'd2,
        alu_and     = 3'd3,
        alu_inc_a   = 3'd4,                         // A + 1
        alu_compare = 3'd7                          // Sets equal and less
    } alu_op_e;

    typedef enum logic [2:0] {
        src_a_pc  = 3'd0,
        src_a_reg = 3'd1                            // Register A
    } src_a_e;

    typedef enum logic [2:0] {
        src_b_reg        = 3'd0,                    // Register B
        src_b_four       = 3'd1,                    // Constant 4
        src_b_imm        = 3'd2,                    // Sign extended immediate
        src_b_branch_imm = 3'd3                     // Immediate shifted for branch offsets
    } src_b_e;

    typedef enum logic [1:0] {
        sh_left        = 2'd0,
        sh_right_logic = 2'd1,
        sh_right_arith = 2'd2,
        sh_none        = 2'd3                       // Shifter passes through
    } shift_e;

    typedef enum logic [2:0] {
        wb_alu    = 3'd0,                           // Register file data from ALU out
        wb_memory = 3'd1                            // Register file data from memory data reg
    } wb_sel_e;

    typedef struct packed {
        logic equal;                                // A == B
        logic less;                                 // A < B, signed
    } alu_flags_t;

    // Decoder output, shared by sequencer and word generator
    typedef struct packed {
        instr_class_e cls;
        branch_kind_e branch_kind;                  // Only meaningful for cls_branch
        alu_op_e      alu_op;                       // Execute setting for decode step
        src_b_e       src_b;
        shift_e       shift;
    } decoded_t;

    typedef struct packed {
        logic       pc_write;
        alu_op_e    alu_op;
        src_a_e     src_a;
        src_b_e     src_b;
        shift_e     shift;
        logic       reg_a_write;
        logic       reg_b_write;
        logic       clear_a;                        // Forces register A to zero
        logic       data_mem_write;
        logic       mem_data_write;                 // Memory data register load
        logic       reg_file_write;
        wb_sel_e    wb_sel;
    } ctrl_word_t;

    // Base word, every step starts from it
    localparam ctrl_word_t ctrl_default = '{
        pc_write:       1'b0,
        alu_op:         alu_pass_a,
        src_a:          src_a_pc,
        src_b:          src_b_reg,
        shift:          sh_none,
        reg_a_write:    1'b0,
        reg_b_write:    1'b0,
        clear_a:        1'b0,
        data_mem_write: 1'b0,
        mem_data_write: 1'b0,
        reg_file_write: 1'b0,
        wb_sel:         wb_alu
    };

endpackage

/* hw/control_unit.sv */
module control_unit import control_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [instr_width-1:0] instruction,     // Stable from fetch to next fetch
    input  alu_flags_t             flags,
    output ctrl_word_t             ctrl,
    output step_e                  step
);

    decoded_t decoded;

    instr_decoder u_decoder (
        .instruction (instruction),
        .decoded     (decoded)
    );

    // Only block with state
    step_sequencer u_sequencer (
        .clock   (clock),
        .reset   (reset),
        .decoded (decoded),
        .step    (step)
    );

    control_word_gen u_word_gen (
        .step    (step),
        .decoded (decoded),
        .flags   (flags),
        .ctrl    (ctrl)                             // Valid in the same cycle as step
    );

endmodule

/* hw/control_word_gen.sv */
module control_word_gen import control_pkg::*; (
    input  step_e      step,
    input  decoded_t   decoded,
    input  alu_flags_t flags,                       // From the compare done in decode
    output ctrl_word_t ctrl
);

    logic is_jump_link;                             // jal or jalr
    logic taken;

    assign is_jump_link = (decoded.cls == cls_jal) || (decoded.cls == cls_jalr);

    // Branch condition from the ALU compare flags
    always_comb begin
        case (decoded.branch_kind)
            br_eq:   taken = flags.equal;
            br_ne:   taken = !flags.equal;
            br_ge:   taken = !flags.less;           // Signed A >= B
            br_lt:   taken = flags.less;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        ctrl = ctrl_default;
        case (step)
            st_idle: begin
                ctrl.clear_a = 1'b1;                // Register A held at zero
            end
            st_fetch: begin
                ctrl.pc_write = 1'b1;               // PC <= PC + 4
                ctrl.alu_op   = alu_add;
                ctrl.src_a    = src_a_pc;
                ctrl.src_b    = src_b_four;
                ctrl.wb_sel   = wb_memory;
            end
            st_decode: begin
                ctrl.reg_a_write = 1'b1;            // Latch rs1 and rs2
                ctrl.reg_b_write = 1'b1;
                ctrl.alu_op      = decoded.alu_op;
                ctrl.src_b       = decoded.src_b;
                ctrl.shift       = decoded.shift;
                ctrl.src_a       = is_jump_link ? src_a_pc : src_a_reg;
                ctrl.clear_a     = (decoded.cls == cls_lui);   // lui adds to zero
            end
            st_set_flag: begin
                // A is cleared, so inc_a gives 1 and pass_a gives 0
                ctrl.clear_a = 1'b1;
                ctrl.src_a   = src_a_reg;
                ctrl.alu_op  = flags.less ? alu_inc_a : alu_pass_a;
            end
            st_write_alu: begin
                ctrl.reg_file_write = 1'b1;
                ctrl.wb_sel         = wb_alu;
                if (is_jump_link) begin
                    ctrl.alu_op = alu_pass_a;       // rd <= return PC
                    ctrl.src_a  = src_a_pc;
                end
            end
            st_write_mem: begin
                ctrl.reg_file_write = 1'b1;         // rd <= load data
                ctrl.wb_sel         = wb_memory;
            end
            st_mem_read: begin
                ctrl.mem_data_write = 1'b1;         // Capture memory read data
            end
            st_mem_write: begin
                ctrl.data_mem_write = 1'b1;         // rs2 to rs1 + imm
            end
            st_jump: begin
                case (decoded.cls)
                    cls_branch: begin
                        if (taken) begin
                            ctrl.pc_write = 1'b1;   // PC <= PC + offset
                            ctrl.alu_op   = alu_add;
                            ctrl.src_a    = src_a_pc;
                            ctrl.src_b    = src_b_branch_imm;
                        end
                    end
                    cls_jal: begin
                        ctrl.pc_write = 1'b1;
                        ctrl.alu_op   = alu_add;
                        ctrl.src_a    = src_a_pc;
                        ctrl.src_b    = src_b_branch_imm;
                    end
                    cls_jalr: begin
                        ctrl.pc_write = 1'b1;       // PC <= rs1 + imm
                        ctrl.alu_op   = alu_add;
                        ctrl.src_a    = src_a_reg;
                        ctrl.src_b    = src_b_imm;
                    end
                    default: ;                      // Not reached for other classes
                endcase
            end
            default: begin
                ctrl.clear_a = 1'b1;                // Same as idle
            end
        endcase
    end

endmodule

/* hw/instr_decoder.sv */
module instr_decoder import control_pkg::*; (
    input  logic [instr_width-1:0] instruction,     // From instruction register
    output decoded_t               decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;                             // RV64 shifts use a 6 bit shamt

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];
    assign funct6 = instruction[31:26];

    // Builds one decode table row, branch kind left at br_eq
    function automatic decoded_t make_row(
        input instr_class_e cls,
        input alu_op_e      alu_op,
        input src_b_e       src_b,
        input shift_e       shift
    );
        decoded_t row;
        row.cls         = cls;
        row.branch_kind = br_eq;
        row.alu_op      = alu_op;
        row.src_b       = src_b;
        row.shift       = shift;
        return row;
    endfunction

    always_comb begin
        decoded = make_row(cls_nop, alu_pass_a, src_b_reg, sh_none);   // Unmatched is nop
        case (opcode)
            op_reg: begin
                if (funct3 == 3'd0 && funct7 == funct7_base) begin
                    decoded = make_row(cls_alu_reg, alu_add, src_b_reg, sh_none);  // add
                end else if (funct3 == 3'd0 && funct7 == funct7_alt) begin
                    decoded = make_row(cls_alu_reg, alu_sub, src_b_reg, sh_none);  // sub
                end else if (funct3 == 3'd7 && funct7 == funct7_base) begin
                    decoded = make_row(cls_alu_reg, alu_and, src_b_reg, sh_none);  // and
                end else if (funct3 == 3'd2 && funct7 == funct7_base) begin
                    decoded = make_row(cls_set_less, alu_compare, src_b_reg, sh_none); // slt
                end
            end
            op_imm: begin
                if (instruction[31:7] == '0) begin
                    decoded = make_row(cls_nop, alu_pass_a, src_b_reg, sh_none);   // addi x0,x0,0
                end else if (funct3 == 3'd0) begin
                    decoded = make_row(cls_alu_imm, alu_add, src_b_imm, sh_none);  // addi
                end else if (funct3 == 3'd2) begin
                    decoded = make_row(cls_set_less, alu_compare, src_b_imm, sh_none); // slti
                end else if (funct3 == 3'd1 && funct6 == funct6_logic) begin
                    decoded = make_row(cls_shift, alu_pass_a, src_b_reg, sh_left); // slli
                end else if (funct3 == 3'd5 && funct6 == funct6_logic) begin
                    decoded = make_row(cls_shift, alu_pass_a, src_b_reg, sh_right_logic);
                end else if (funct3 == 3'd5 && funct6 == funct6_arith) begin
                    decoded = make_row(cls_shift, alu_pass_a, src_b_reg, sh_right_arith);
                end
            end
            op_system: begin
                decoded = make_row(cls_break, alu_pass_a, src_b_reg, sh_none);
            end
            op_load: begin
                if (funct3 != 3'd7) begin                   // ld lb lh lw lbu lhu lwu
                    decoded = make_row(cls_load, alu_add, src_b_imm, sh_none);
                end
            end
            op_store: begin
                // sb 0, sh 1, sw 2, sd 7 in this encoding
                if (funct3 inside {3'd0, 3'd1, 3'd2, 3'd7}) begin
                    decoded = make_row(cls_store, alu_add, src_b_imm, sh_none);
                end
            end
            op_branch: begin
                if (funct3 == 3'd0) begin                   // beq
                    decoded = make_row(cls_branch, alu_compare, src_b_reg, sh_none);
                end
            end
            op_branch_jalr: begin
                case (funct3)
                    3'd0: decoded = make_row(cls_jalr, alu_pass_a, src_b_reg, sh_none);
                    3'd1: begin
                        decoded = make_row(cls_branch, alu_compare, src_b_reg, sh_none);
                        decoded.branch_kind = br_ne;
                    end
                    3'd4: begin
                        decoded = make_row(cls_branch, alu_compare, src_b_reg, sh_none);
                        decoded.branch_kind = br_lt;
                    end
                    3'd5: begin
                        decoded = make_row(cls_branch, alu_compare, src_b_reg, sh_none);
                        decoded.branch_kind = br_ge;
                    end
                    default: ;                              // Stays nop
                endcase
            end
            op_lui: begin
                decoded = make_row(cls_lui, alu_add, src_b_imm, sh_none);  // 0 + upper imm
            end
            op_jal: begin
                decoded = make_row(cls_jal, alu_pass_a, src_b_reg, sh_none);
            end
            default: ;
        endcase
    end

endmodule

/* hw/step_sequencer.sv */
module step_sequencer import control_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  decoded_t decoded,                       // Class picks the path after decode
    output step_e    step
);

    step_e next_step;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            step <= st_idle;
        end else begin
            step <= next_step;
        end
    end

    // First execute step by class
    function automatic step_e first_step(input instr_class_e cls);
        case (cls)
            cls_alu_reg,
            cls_alu_imm,
            cls_shift,
            cls_lui,
            cls_jal,
            cls_jalr:     return st_write_alu;      // Link value written before the jump
            cls_set_less: return st_set_flag;
            cls_load:     return st_mem_read;
            cls_store:    return st_mem_write;
            cls_branch:   return st_jump;
            cls_break:    return st_decode;         // Parked until reset
            default:      return st_fetch;          // nop and unknown
        endcase
    endfunction

    always_comb begin
        case (step)
            st_idle:      next_step = st_fetch;
            st_fetch:     next_step = st_decode;
            st_decode:    next_step = first_step(decoded.cls);
            st_set_flag:  next_step = st_write_alu;
            st_write_alu: begin
                if (decoded.cls == cls_jal || decoded.cls == cls_jalr) begin
                    next_step = st_jump;
                end else begin
                    next_step = st_fetch;
                end
            end
            st_mem_read:  next_step = st_write_mem;
            st_write_mem: next_step = st_fetch;
            st_mem_write: next_step = st_fetch;
            st_jump:      next_step = st_fetch;
            default:      next_step = st_idle;      // Unused encodings recover
        endcase
    end

endmodule
